// ==== bench/stim_datapath_memory.txt ====
// cmd addr wdata expected, cmd 0 redirect, 1 store, 2 load of expected, 3 load of unwritten line
// cmd f ends the list
3 00100000 0 0
1 00100000 1122334455667788 0
2 00100000 0 1122334455667788
0 00002004 0 0
3 00100040 0 0
1 00100008 a5a5a5a5deadbeef 0
1 00100010 0123456789abcdef 0
2 00100008 0 a5a5a5a5deadbeef
2 00100010 0 0123456789abcdef
0 00001804 0 0
1 00100008 0f0f0f0f0f0f0f0f 0
2 00100008 0 0f0f0f0f0f0f0f0f
3 00100100 0 0
3 00100108 0 0
0 00003000 0 0
1 00100200 cafef00d12345678 0
1 00100208 8765432100000001 0
2 00100200 0 cafef00d12345678
2 00100208 0 8765432100000001
2 00100000 0 1122334455667788
0 0000100c 0 0
3 00100300 0 0
1 00100300 ffffffff00000000 0
2 00100300 0 ffffffff00000000
f 0 0 0

// ==== bench/tb_datapath_memory.sv ====
`default_nettype none

module tb_datapath_memory;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          RESET_CYCLES = 8;
	localparam int          MAX_RECS     = 64;
	localparam logic [63:0] SEED         = 64'd9792;

	logic                clk_i = 1'b0;
	logic                rst_n_i;
	logic                redirect_i;
	logic [31:0]         redirect_pc_i;
	logic                instr_ready_i;
	logic                instr_valid_o;
	logic [31:0]         instr_o;
	logic [31:0]         instr_pc_o;
	logic                ls_valid_i;
	memsys_pkg::ls_op_e  ls_op_i;
	logic [31:0]         ls_addr_i;
	logic [63:0]         ls_wdata_i;
	logic                ls_ready_o;
	logic                ls_ans_valid_o;
	logic [63:0]         ls_rdata_o;
	logic                mem_req_valid_o;
	logic                mem_req_ready_i;
	logic                mem_req_we_o;
	logic [31:0]         mem_req_addr_o;
	logic [63:0]         mem_req_wdata_o;
	memsys_pkg::src_id_e mem_req_src_o;
	logic                mem_ans_valid_i;
	memsys_pkg::src_id_e mem_ans_src_i;
	logic [63:0]         mem_ans_data_i;

	// Memory model and scoreboard state
	logic [63:0]         mem_model [logic [31:0]];
	logic [63:0]         stim [MAX_RECS*4];
	memsys_pkg::src_id_e pend_src [$];
	logic [63:0]         pend_data [$];
	int                  pend_due [$];
	logic [63:0]         exp_loads [$];
	memsys_pkg::ls_op_e  queued_ops [$];
	logic [63:0]         rng = SEED;
	logic [63:0]         cur_exp = '0;
	logic [31:0]         next_pc = memsys_pkg::BOOT_PC;
	int                  cycle = 0;
	int                  instr_count = 0;
	int                  n_recs = 0;
	logic                stim_loaded = 1'b0;
	logic                ls_accepted = 1'b0;
	logic                served = 1'b0;
	logic                held = 1'b0;
	memsys_pkg::src_id_e last_src = memsys_pkg::SRC_FETCH;
	memsys_pkg::src_id_e held_src = memsys_pkg::SRC_FETCH;

	datapath_memory i_datapath_memory (.*);

	initial begin
		forever #2 clk_i = ~clk_i;
	end

	function automatic logic [63:0] xorshift64(input logic [63:0] x);
		logic [63:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 7);
		s = s ^ (s << 17);
		return s;
	endfunction

	function automatic logic [63:0] next_rand();
		rng = xorshift64(rng);
		return rng;
	endfunction

	// Content of a line that was never written
	function automatic logic [63:0] init_value(input logic [31:0] addr);
		return xorshift64({addr[31:3], 3'b000, SEED[31:0]});
	endfunction

	function automatic logic [63:0] line_value(input logic [31:0] addr);
		logic [31:0] base;
		base = {addr[31:3], 3'b000};
		if (mem_model.exists(base)) begin
			return mem_model[base];
		end
		return init_value(base);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_instr(input logic [memsys_pkg::INSTR_W-1:0] got_instr,
			input logic [memsys_pkg::INSTR_W-1:0] exp_instr,
			input logic [memsys_pkg::ADDR_W-1:0] got_pc,
			input logic [memsys_pkg::ADDR_W-1:0] exp_pc);
		if (got_pc !== exp_pc) begin
			abort_run($sformatf("CHECK FAILED instr_pc_o got %h expected %h", got_pc, exp_pc));
		end else if (got_instr !== exp_instr) begin
			abort_run($sformatf("CHECK FAILED instr_o got %h expected %h", got_instr, exp_instr));
		end
	endtask

	task automatic check_load(input memsys_pkg::mem_word_u got, input memsys_pkg::mem_word_u exp);
		if (got.dword !== exp.dword) begin
			abort_run($sformatf("CHECK FAILED ls_rdata_o got %h expected %h", got.dword, exp.dword));
		end
	endtask

	task automatic check_req_src(input memsys_pkg::src_id_e got, input memsys_pkg::src_id_e exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED mem_req_src_o got %h expected %h", got, exp));
		end
	endtask

	// Random stalls and out of order answers on the falling edge
	always @(negedge clk_i) begin : memory_drive
		int          idx;
		logic [63:0] r;
		idx = -1;
		if (rst_n_i) begin
			r = next_rand();
			instr_ready_i   = (r[1:0] != 2'b00);
			mem_req_ready_i = (r[9:8] != 2'b00);
			mem_ans_valid_i = 1'b0;
			for (int i = 0; i < pend_due.size(); i++) begin
				if (idx < 0 && pend_due[i] <= cycle) begin
					idx = i;
				end
			end
			if (idx >= 0) begin
				mem_ans_valid_i = 1'b1;
				mem_ans_src_i   = pend_src[idx];
				mem_ans_data_i  = pend_data[idx];
				pend_src.delete(idx);
				pend_data.delete(idx);
				pend_due.delete(idx);
			end
		end
	end

	always @(posedge clk_i) begin : monitor
		logic [63:0]         line;
		logic [63:0]         r;
		logic                exp_we;
		memsys_pkg::src_id_e exp_src;
		cycle = cycle + 1;
		if (rst_n_i) begin
			// Stores write the model as soon as they are accepted
			if (mem_req_valid_o && mem_req_ready_i) begin
				// Fetch only reads, the queue issues its ops in program order
				if (mem_req_src_o == memsys_pkg::SRC_FETCH) begin
					check_flag("mem_req_we_o", mem_req_we_o, 1'b0);
				end else if (queued_ops.size() == 0) begin
					abort_run("The load/store side issued a request with nothing queued");
				end else begin
					exp_we = (queued_ops.pop_front() == memsys_pkg::LS_STORE);
					check_flag("mem_req_we_o", mem_req_we_o, exp_we);
				end
				line = line_value(mem_req_addr_o);
				if (mem_req_we_o) begin
					mem_model[{mem_req_addr_o[31:3], 3'b000}] = mem_req_wdata_o;
				end
				r = next_rand();
				pend_src.push_back(mem_req_src_o);
				pend_data.push_back(line);
				pend_due.push_back(cycle + 1 + int'(r[1:0]));
			end

			// Round robin when both peers want the port and a held grant under a stall
			if (mem_req_valid_o) begin
				if (last_src == memsys_pkg::SRC_FETCH) begin
					exp_src = memsys_pkg::SRC_LSQ;
				end else begin
					exp_src = memsys_pkg::SRC_FETCH;
				end
				if (held) begin
					check_req_src(mem_req_src_o, held_src);
				end else if (served && i_datapath_memory.fetch_if.req_valid
						&& i_datapath_memory.lsq_if.req_valid) begin
					check_req_src(mem_req_src_o, exp_src);
				end
			end
			held     = mem_req_valid_o && !mem_req_ready_i;
			held_src = mem_req_src_o;
			if (mem_req_valid_o && mem_req_ready_i) begin
				last_src = mem_req_src_o;
				served   = 1'b1;
			end

			// Lower address sits in the low half of a line
			if (instr_valid_o && instr_ready_i) begin
				line = line_value(next_pc);
				check_instr(instr_o, next_pc[2] ? line[63:32] : line[31:0], instr_pc_o, next_pc);
				next_pc     = next_pc + 32'd4;
				instr_count = instr_count + 1;
			end
			if (redirect_i) begin
				next_pc = redirect_pc_i;
			end

			ls_accepted = ls_valid_i && ls_ready_o;
			if (ls_accepted) begin
				queued_ops.push_back(ls_op_i);
			end
			if (ls_accepted && ls_op_i == memsys_pkg::LS_LOAD) begin
				exp_loads.push_back(cur_exp);
			end
			if (ls_ans_valid_o) begin
				if (exp_loads.size() == 0) begin
					abort_run("A load answer came back with no load outstanding");
				end else begin
					check_load(ls_rdata_o, exp_loads.pop_front());
				end
			end
		end
	end

	initial begin : stimulus
		logic [63:0] cmd;
		logic [31:0] addr;
		int          target;
		rst_n_i         = 1'b0;
		redirect_i      = 1'b0;
		redirect_pc_i   = '0;
		instr_ready_i   = 1'b0;
		ls_valid_i      = 1'b0;
		ls_op_i         = memsys_pkg::LS_LOAD;
		ls_addr_i       = '0;
		ls_wdata_i      = '0;
		mem_req_ready_i = 1'b0;
		mem_ans_valid_i = 1'b0;
		mem_ans_src_i   = memsys_pkg::SRC_FETCH;
		mem_ans_data_i  = '0;

		$readmemh("bench/stim_datapath_memory.txt", stim);
		while (n_recs < MAX_RECS && stim[4*n_recs] !== 64'hf) begin
			n_recs = n_recs + 1;
		end
		stim_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk_i);
		@(negedge clk_i);
		check_flag("instr_valid_o", instr_valid_o, 1'b0);
		check_flag("mem_req_valid_o", mem_req_valid_o, 1'b0);
		check_flag("ls_ans_valid_o", ls_ans_valid_o, 1'b0);
		check_flag("ls_ready_o", ls_ready_o, 1'b1);
		rst_n_i = 1'b1;

		for (int n = 0; n < n_recs; n++) begin
			cmd  = stim[4*n];
			addr = stim[4*n+1][31:0];
			if (cmd == 64'd0) begin
				ls_valid_i    = 1'b0;
				redirect_i    = 1'b1;
				redirect_pc_i = addr;
				@(negedge clk_i);
				redirect_i = 1'b0;
				// Let the new path deliver a few instructions
				target = instr_count + 4;
				while (instr_count < target) @(negedge clk_i);
			end else begin
				if (cmd == 64'd1) begin
					ls_op_i = memsys_pkg::LS_STORE;
				end else begin
					ls_op_i = memsys_pkg::LS_LOAD;
				end
				if (cmd == 64'd3) begin
					cur_exp = init_value(addr);
				end else begin
					cur_exp = stim[4*n+3];
				end
				ls_valid_i = 1'b1;
				ls_addr_i  = addr;
				ls_wdata_i = stim[4*n+2];
				do @(negedge clk_i); while (!ls_accepted);
			end
		end
		ls_valid_i = 1'b0;

		while (exp_loads.size() != 0) @(negedge clk_i);
		if (instr_count == 0) begin
			abort_run("Fetch never delivered an instruction");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

	initial begin : watchdog
		wait (stim_loaded);
		repeat (RESET_CYCLES + 200 * n_recs + 50) @(posedge clk_i);
		abort_run("Timeout, the DUT stopped making progress");
	end

endmodule

`default_nettype wire

// ==== files.f ====
logic/memsys_pkg.sv
logic/mem_client_if.sv
logic/fetch_unit.sv
logic/lsq_unit.sv
logic/mem_arbiter.sv
logic/datapath_memory.sv
bench/tb_datapath_memory.sv

// ==== logic/datapath_memory.sv ====
`default_nettype none

module datapath_memory (
	input  wire logic                          clk_i,
	input  wire logic                          rst_n_i,

	// Fetch side
	input  wire logic                          redirect_i,
	input  wire logic [memsys_pkg::ADDR_W-1:0] redirect_pc_i,
	input  wire logic                          instr_ready_i,
	output logic                               instr_valid_o,
	output logic [memsys_pkg::INSTR_W-1:0]     instr_o,
	output logic [memsys_pkg::ADDR_W-1:0]      instr_pc_o,

	// Load/store side
	input  wire logic                          ls_valid_i,
	input  wire memsys_pkg::ls_op_e            ls_op_i,
	input  wire logic [memsys_pkg::ADDR_W-1:0] ls_addr_i,
	input  wire logic [memsys_pkg::LINE_W-1:0] ls_wdata_i,
	output logic                               ls_ready_o,
	output logic                               ls_ans_valid_o,
	output logic [memsys_pkg::LINE_W-1:0]      ls_rdata_o,

	// External memory with tagged answers
	output logic                               mem_req_valid_o,
	input  wire logic                          mem_req_ready_i,
	output logic                               mem_req_we_o,
	output logic [memsys_pkg::ADDR_W-1:0]      mem_req_addr_o,
	output logic [memsys_pkg::LINE_W-1:0]      mem_req_wdata_o,
	output memsys_pkg::src_id_e                mem_req_src_o,
	input  wire logic                          mem_ans_valid_i,
	input  wire memsys_pkg::src_id_e           mem_ans_src_i,
	input  wire logic [memsys_pkg::LINE_W-1:0] mem_ans_data_i
);

	mem_client_if fetch_if ();
	mem_client_if lsq_if ();

	fetch_unit i_fetch_unit (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.instr_ready_i (instr_ready_i),
		.instr_valid_o (instr_valid_o),
		.instr_o       (instr_o),
		.instr_pc_o    (instr_pc_o),
		.mem           (fetch_if.client)
	);

	lsq_unit i_lsq_unit (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.ls_valid_i     (ls_valid_i),
		.ls_op_i        (ls_op_i),
		.ls_addr_i      (ls_addr_i),
		.ls_wdata_i     (ls_wdata_i),
		.ls_ready_o     (ls_ready_o),
		.ls_ans_valid_o (ls_ans_valid_o),
		.ls_rdata_o     (ls_rdata_o),
		.mem            (lsq_if.client)
	);

	mem_arbiter i_mem_arbiter (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.fetch           (fetch_if.arbiter),
		.lsq             (lsq_if.arbiter),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_req_ready_i (mem_req_ready_i),
		.mem_req_we_o    (mem_req_we_o),
		.mem_req_addr_o  (mem_req_addr_o),
		.mem_req_wdata_o (mem_req_wdata_o),
		.mem_req_src_o   (mem_req_src_o),
		.mem_ans_valid_i (mem_ans_valid_i),
		.mem_ans_src_i   (mem_ans_src_i),
		.mem_ans_data_i  (mem_ans_data_i)
	);

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`default_nettype none

module fetch_unit (
	input  wire logic                          clk_i,
	input  wire logic                          rst_n_i,
	input  wire logic                          redirect_i,
	input  wire logic [memsys_pkg::ADDR_W-1:0] redirect_pc_i,
	input  wire logic                          instr_ready_i,
	output logic                               instr_valid_o,
	output logic [memsys_pkg::INSTR_W-1:0]     instr_o,
	output logic [memsys_pkg::ADDR_W-1:0]      instr_pc_o,
	mem_client_if.client                       mem
);

	// pc is kept as a line address plus a slot index
	logic [memsys_pkg::ADDR_W-1:0] line_pc_q, line_pc_d;
	logic                          slot_q, slot_d;
	memsys_pkg::mem_word_u         line_q, line_d;
	logic                          line_valid_q, line_valid_d;
	logic                          req_valid_q, req_valid_d;
	logic [memsys_pkg::ADDR_W-1:0] req_addr_q, req_addr_d;
	logic                          wait_q, wait_d;
	logic                          drop_q, drop_d;

	always_comb begin
		line_pc_d    = line_pc_q;
		slot_d       = slot_q;
		line_d       = line_q;
		line_valid_d = line_valid_q;
		req_valid_d  = req_valid_q;
		req_addr_d   = req_addr_q;
		wait_d       = wait_q;
		drop_d       = drop_q;

		if (req_valid_q && mem.req_ready) begin
			req_valid_d = 1'b0;
			wait_d      = 1'b1;
		end

		// A stale answer only frees the outstanding request
		if (mem.ans_valid) begin
			wait_d = 1'b0;
			drop_d = 1'b0;
			if (!drop_q) begin
				line_d       = mem.ans_data;
				line_valid_d = 1'b1;
			end
		end

		if (line_valid_q && instr_ready_i) begin
			if (slot_q) begin
				line_valid_d = 1'b0;
				slot_d       = 1'b0;
				line_pc_d    = line_pc_q + memsys_pkg::LINE_BYTES;
			end else begin
				slot_d = 1'b1;
			end
		end

		// Whatever is still outstanding after this cycle belongs to the old path
		if (redirect_i) begin
			line_valid_d = 1'b0;
			line_pc_d    = memsys_pkg::line_base(redirect_pc_i);
			slot_d       = redirect_pc_i[memsys_pkg::LINE_OFS_W-1];
			drop_d       = req_valid_d || wait_d;
		end

		// Fetch the line holding the pc once nothing is pending
		if (!req_valid_d && !wait_d && !line_valid_d) begin
			req_valid_d = 1'b1;
			req_addr_d  = line_pc_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			line_pc_q    <= memsys_pkg::line_base(memsys_pkg::BOOT_PC);
			slot_q       <= memsys_pkg::BOOT_PC[memsys_pkg::LINE_OFS_W-1];
			line_valid_q <= 1'b0;
			req_valid_q  <= 1'b0;
			wait_q       <= 1'b0;
			drop_q       <= 1'b0;
		end else begin
			line_pc_q    <= line_pc_d;
			slot_q       <= slot_d;
			line_valid_q <= line_valid_d;
			req_valid_q  <= req_valid_d;
			wait_q       <= wait_d;
			drop_q       <= drop_d;
		end
	end

	always_ff @(posedge clk_i) begin
		line_q     <= line_d;
		req_addr_q <= req_addr_d;
	end

	// Fetch only reads
	assign mem.req_valid = req_valid_q;
	assign mem.req_we    = 1'b0;
	assign mem.req_addr  = req_addr_q;
	assign mem.req_wdata = '0;

	assign instr_valid_o = line_valid_q;
	assign instr_o       = line_q.slot[slot_q];
	assign instr_pc_o    = {line_pc_q[memsys_pkg::ADDR_W-1:memsys_pkg::LINE_OFS_W], slot_q, 2'b00};

endmodule

`default_nettype wire

// ==== logic/lsq_unit.sv ====
`default_nettype none

module lsq_unit (
	input  wire logic                          clk_i,
	input  wire logic                          rst_n_i,
	input  wire logic                          ls_valid_i,
	input  wire memsys_pkg::ls_op_e            ls_op_i,
	input  wire logic [memsys_pkg::ADDR_W-1:0] ls_addr_i,
	input  wire logic [memsys_pkg::LINE_W-1:0] ls_wdata_i,
	output logic                               ls_ready_o,
	output logic                               ls_ans_valid_o,
	output logic [memsys_pkg::LINE_W-1:0]      ls_rdata_o,
	mem_client_if.client                       mem
);

	// Queue storage
	memsys_pkg::ls_op_e            op_q   [memsys_pkg::LSQ_DEPTH];
	logic [memsys_pkg::ADDR_W-1:0] addr_q [memsys_pkg::LSQ_DEPTH];
	logic [memsys_pkg::LINE_W-1:0] data_q [memsys_pkg::LSQ_DEPTH];

	logic [memsys_pkg::LSQ_PTR_W-1:0] wr_ptr_q;
	logic [memsys_pkg::LSQ_PTR_W-1:0] rd_ptr_q;
	logic [memsys_pkg::LSQ_PTR_W:0]   count_q;
	logic                             inflight_q;
	logic                             push;
	logic                             pop;
	logic                             head_load;

	assign ls_ready_o = (count_q != memsys_pkg::LSQ_FULL);
	assign push       = ls_valid_i && ls_ready_o;

	// Only the head is ever in flight, so any answer retires it
	assign pop        = mem.ans_valid;
	assign head_load  = (op_q[rd_ptr_q] == memsys_pkg::LS_LOAD);

	always_ff @(posedge clk_i) begin
		if (push) begin
			op_q[wr_ptr_q]   <= ls_op_i;
			addr_q[wr_ptr_q] <= ls_addr_i;
			data_q[wr_ptr_q] <= ls_wdata_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr_q       <= '0;
			rd_ptr_q       <= '0;
			count_q        <= '0;
			inflight_q     <= 1'b0;
			ls_ans_valid_o <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end

			if (push && !pop) begin
				count_q <= count_q + 1'b1;
			end else if (pop && !push) begin
				count_q <= count_q - 1'b1;
			end

			if (mem.req_valid && mem.req_ready) begin
				inflight_q <= 1'b1;
			end else if (pop) begin
				inflight_q <= 1'b0;
			end

			// stores retire without telling anyone
			ls_ans_valid_o <= pop && head_load;
		end
	end

	always_ff @(posedge clk_i) begin
		if (pop) begin
			ls_rdata_o <= mem.ans_data.dword;
		end
	end

	// Head goes out as a doubleword request
	assign mem.req_valid = (count_q != '0) && !inflight_q;
	assign mem.req_we    = (op_q[rd_ptr_q] == memsys_pkg::LS_STORE);
	assign mem.req_addr  = memsys_pkg::line_base(addr_q[rd_ptr_q]);
	assign mem.req_wdata = data_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
	input  wire logic                          clk_i,
	input  wire logic                          rst_n_i,
	mem_client_if.arbiter                      fetch,
	mem_client_if.arbiter                      lsq,
	output logic                               mem_req_valid_o,
	input  wire logic                          mem_req_ready_i,
	output logic                               mem_req_we_o,
	output logic [memsys_pkg::ADDR_W-1:0]      mem_req_addr_o,
	output logic [memsys_pkg::LINE_W-1:0]      mem_req_wdata_o,
	output memsys_pkg::src_id_e                mem_req_src_o,
	input  wire logic                          mem_ans_valid_i,
	input  wire memsys_pkg::src_id_e           mem_ans_src_i,
	input  wire logic [memsys_pkg::LINE_W-1:0] mem_ans_data_i
);

	memsys_pkg::src_id_e last_q;
	memsys_pkg::src_id_e lock_src_q;
	logic                lock_q;
	memsys_pkg::src_id_e gnt;

	// Round robin, except a stalled grant keeps its slot
	always_comb begin
		if (lock_q) begin
			gnt = lock_src_q;
		end else if (fetch.req_valid && lsq.req_valid) begin
			gnt = (last_q == memsys_pkg::SRC_FETCH) ? memsys_pkg::SRC_LSQ : memsys_pkg::SRC_FETCH;
		end else if (lsq.req_valid) begin
			gnt = memsys_pkg::SRC_LSQ;
		end else begin
			gnt = memsys_pkg::SRC_FETCH;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			last_q     <= memsys_pkg::SRC_LSQ;
			lock_src_q <= memsys_pkg::SRC_FETCH;
			lock_q     <= 1'b0;
		end else begin
			if (mem_req_valid_o && mem_req_ready_i) begin
				last_q <= gnt;
			end
			lock_q     <= mem_req_valid_o && !mem_req_ready_i;
			lock_src_q <= gnt;
		end
	end

	// Request mux onto the single port
	assign mem_req_valid_o = (gnt == memsys_pkg::SRC_FETCH) ? fetch.req_valid : lsq.req_valid;
	assign mem_req_we_o    = (gnt == memsys_pkg::SRC_FETCH) ? fetch.req_we : lsq.req_we;
	assign mem_req_addr_o  = (gnt == memsys_pkg::SRC_FETCH) ? fetch.req_addr : lsq.req_addr;
	assign mem_req_wdata_o = (gnt == memsys_pkg::SRC_FETCH) ? fetch.req_wdata : lsq.req_wdata;
	assign mem_req_src_o   = gnt;

	assign fetch.req_ready = mem_req_ready_i && (gnt == memsys_pkg::SRC_FETCH);
	assign lsq.req_ready   = mem_req_ready_i && (gnt == memsys_pkg::SRC_LSQ);

	// Answers go back by their tag
	assign fetch.ans_valid = mem_ans_valid_i && (mem_ans_src_i == memsys_pkg::SRC_FETCH);
	assign lsq.ans_valid   = mem_ans_valid_i && (mem_ans_src_i == memsys_pkg::SRC_LSQ);
	assign fetch.ans_data  = mem_ans_data_i;
	assign lsq.ans_data    = mem_ans_data_i;

endmodule

`default_nettype wire

// ==== logic/mem_client_if.sv ====
`default_nettype none

interface mem_client_if;

	// Request side, one transfer per valid and ready cycle
	logic                          req_valid;
	logic                          req_ready;
	logic                          req_we;
	logic [memsys_pkg::ADDR_W-1:0] req_addr;
	logic [memsys_pkg::LINE_W-1:0] req_wdata;

	// Answer side, single-cycle pulse with no back-pressure
	logic                          ans_valid;
	memsys_pkg::mem_word_u         ans_data;

	modport client (
		output req_valid, req_we, req_addr, req_wdata,
		input  req_ready, ans_valid, ans_data
	);

	modport arbiter (
		input  req_valid, req_we, req_addr, req_wdata,
		output req_ready, ans_valid, ans_data
	);

endinterface

`default_nettype wire

// ==== logic/memsys_pkg.sv ====
`default_nettype none

package memsys_pkg;

	// Byte address and data widths
	localparam int unsigned ADDR_W  = 32;
	localparam int unsigned LINE_W  = 64;
	localparam int unsigned INSTR_W = 32;

	// One memory word is exactly one fetch line
	localparam int unsigned       LINE_OFS_W = $clog2(LINE_W / 8);
	localparam logic [ADDR_W-1:0] LINE_BYTES = ADDR_W'(LINE_W / 8);

	localparam logic [ADDR_W-1:0] BOOT_PC = 32'h0000_1000;

	// Load/store queue sizing
	localparam int unsigned          LSQ_DEPTH = 2;
	localparam int unsigned          LSQ_PTR_W = $clog2(LSQ_DEPTH);
	localparam logic [LSQ_PTR_W:0]   LSQ_FULL  = (LSQ_PTR_W + 1)'(LSQ_DEPTH);

	// Who issued a request, echoed back on its answer
	typedef enum logic {
		SRC_FETCH = 1'b0,
		SRC_LSQ   = 1'b1
	} src_id_e;

	typedef enum logic {
		LS_LOAD  = 1'b0,
		LS_STORE = 1'b1
	} ls_op_e;

	// Fetch sees two instruction slots, the load/store side sees one doubleword
	// slot[0] holds the lower address
	typedef union packed {
		logic [1:0][INSTR_W-1:0] slot;
		logic [LINE_W-1:0]       dword;
	} mem_word_u;

	// Clears the byte offset inside a line
	function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] addr);
		return {addr[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
	endfunction

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_datapath_memory \
	-Mdir obj_dir || { echo "Build failed"; exit 1; }

./obj_dir/Vtb_datapath_memory > sim.log 2>&1
cat sim.log

grep -qx "Verification passed" sim.log && echo "Simulation OK" || { echo "Simulation FAILED"; exit 1; }
